// File: Bender.yml
package:
  name: rv_exec

sources:
  - rtl/rv_core_pkg.sv
  - rtl/rv_decoder.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_exec_top.sv

// File: rtl/rv_alu.sv
//////////////////////////////////////////////////
// Execute stage
// Operand select, integer ALU, result register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,

  // From the decoder
  input  logic      valid_i,
  input  logic      illegal_i,
  input  alu_op_t   alu_op_i,
  input  logic      use_rs2_i,
  input  logic      use_pc_i,
  input  logic      zero_a_i,
  input  word_t     rs_a_i,      // Register file read data
  input  word_t     rs_b_i,
  input  word_t     imm_i,
  input  word_t     pc_i,
  input  reg_addr_t rd_i,
  input  logic      wb_i,
  input  logic      lsu_req_i,
  input  lsu_ctrl_t lsu_ctrl_i,

  // Registered results
  output word_t     result_o,
  output reg_addr_t rd_o,
  output logic      wb_valid_o,
  output logic      lsu_req_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output word_t     lsu_wdata_o,
  output logic      illegal_o
);

  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      result_d;

  assign op_a  = use_pc_i ? pc_i : (zero_a_i ? '0 : rs_a_i);
  assign op_b  = use_rs2_i ? rs_b_i : imm_i;
  assign shamt = op_b[4:0];

  //////////////////////////////////////////////////
  // Integer operations

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_d = op_a + op_b;
      ALU_SUB:  result_d = op_a - op_b;
      ALU_SLL:  result_d = op_a << shamt;
      ALU_SLT:  result_d = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result_d = {31'b0, op_a < op_b};
      ALU_XOR:  result_d = op_a ^ op_b;
      ALU_SRL:  result_d = op_a >> shamt;
      ALU_SRA:  result_d = $signed(op_a) >>> shamt;
      ALU_OR:   result_d = op_a | op_b;
      ALU_AND:  result_d = op_a & op_b;
      default:  result_d = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Output registers

  // One-cycle pulses
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o <= 1'b0;
      lsu_req_o  <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      wb_valid_o <= valid_i & wb_i;
      lsu_req_o  <= valid_i & lsu_req_i;
      illegal_o  <= valid_i & illegal_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;  // Also the memory address
      rd_o     <= rd_i;
    end
    if (valid_i && lsu_req_i) begin
      lsu_ctrl_o  <= lsu_ctrl_i;
      lsu_wdata_o <= rs_b_i;  // Store data straight from rs2
    end
  end

endmodule

// File: rtl/rv_core_pkg.sv
//////////////////////////////////////////////////
// RV32I core package
// Widths, vector types, opcodes and ALU encoding
//////////////////////////////////////////////////

package rv_core_pkg;

  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned REG_ADDR_WIDTH = 5;
  localparam int unsigned OPCODE_WIDTH   = 7;
  localparam int unsigned ALU_OP_WIDTH   = 4;
  localparam int unsigned LSU_CTRL_WIDTH = 4;

  typedef logic [DATA_WIDTH-1:0]     word_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [OPCODE_WIDTH-1:0]   opcode_t;
  typedef logic [ALU_OP_WIDTH-1:0]   alu_op_t;    // {instr[30], funct3}
  typedef logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_t;  // {store, funct3}

  //////////////////////////////////////////////////
  // Major opcodes
  localparam opcode_t OPCODE_LOAD    = 7'b000_0011;
  localparam opcode_t OPCODE_MISCMEM = 7'b000_1111;
  localparam opcode_t OPCODE_OPIMM   = 7'b001_0011;
  localparam opcode_t OPCODE_AUIPC   = 7'b001_0111;
  localparam opcode_t OPCODE_STORE   = 7'b010_0011;
  localparam opcode_t OPCODE_OP      = 7'b011_0011;
  localparam opcode_t OPCODE_LUI     = 7'b011_0111;
  localparam opcode_t OPCODE_BRANCH  = 7'b110_0011;
  localparam opcode_t OPCODE_JALR    = 7'b110_0111;
  localparam opcode_t OPCODE_JAL     = 7'b110_1111;
  localparam opcode_t OPCODE_SYSTEM  = 7'b111_0011;

  //////////////////////////////////////////////////
  // ALU operations, bit 30 above funct3
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

endpackage

// File: rtl/rv_decoder.sv
//////////////////////////////////////////////////
// RV32I decoder
// Registers operand selects, immediate, ALU op
// and writeback / memory controls per instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,

  // Incoming instruction
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,

  // Decoded fields, one cycle later
  output logic      valid_o,
  output logic      illegal_o,
  output alu_op_t   alu_op_o,
  output logic      use_rs2_o,   // Operand B from rs2, else immediate
  output logic      use_pc_o,    // Operand A from pc
  output logic      zero_a_o,    // Operand A forced to zero
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output word_t     imm_o,
  output word_t     pc_o,
  output logic      wb_o,
  output logic      lsu_req_o,
  output lsu_ctrl_t lsu_ctrl_o
);

  // Instruction fields
  opcode_t    opcode;
  logic [2:0] funct3;
  reg_addr_t  rs1_field;
  reg_addr_t  rs2_field;
  reg_addr_t  rd_field;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign rs1_field = instr_i[19:15];
  assign rs2_field = instr_i[24:20];
  assign rd_field  = instr_i[11:7];

  //////////////////////////////////////////////////
  // Sign-extended immediates

  word_t imm_itype;
  word_t imm_stype;
  word_t imm_btype;
  word_t imm_jtype;
  word_t imm_utype;

  assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_stype = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};
  assign imm_utype = {instr_i[31:12], 12'b0};

  //////////////////////////////////////////////////
  // Opcode decode

  logic      illegal_d;
  alu_op_t   alu_op_d;
  logic      use_rs2_d;
  logic      use_pc_d;
  logic      zero_a_d;
  reg_addr_t rd_d;
  word_t     imm_d;
  logic      wb_d;
  logic      lsu_req_d;

  always_comb begin
    illegal_d = 1'b0;
    alu_op_d  = ALU_ADD;
    use_rs2_d = 1'b0;
    use_pc_d  = 1'b0;
    zero_a_d  = 1'b0;
    rd_d      = rd_field;
    imm_d     = imm_itype;
    wb_d      = 1'b0;
    lsu_req_d = 1'b0;

    case (opcode)
      OPCODE_OPIMM: begin
        // Bit 30 only matters for SRLI / SRAI
        alu_op_d = (funct3 == 3'b101) ? {instr_i[30], funct3} : {1'b0, funct3};
        wb_d     = 1'b1;
      end
      OPCODE_OP: begin
        // SUB and SRA are the only users of bit 30
        if (funct3 == 3'b000 || funct3 == 3'b101) begin
          alu_op_d = {instr_i[30], funct3};
        end else begin
          alu_op_d = {1'b0, funct3};
        end
        use_rs2_d = 1'b1;
        wb_d      = 1'b1;
      end
      OPCODE_LUI: begin
        zero_a_d = 1'b1;  // 0 + U immediate
        imm_d    = imm_utype;
        wb_d     = 1'b1;
      end
      OPCODE_AUIPC: begin
        use_pc_d = 1'b1;  // pc + U immediate
        imm_d    = imm_utype;
        wb_d     = 1'b1;
      end
      OPCODE_LOAD: begin
        lsu_req_d = 1'b1;   // Address is rs1 + I immediate
      end
      OPCODE_STORE: begin
        imm_d     = imm_stype;
        rd_d      = '0;     // No destination, bits hold the offset
        lsu_req_d = 1'b1;
      end
      OPCODE_BRANCH: begin
        imm_d     = imm_btype;
        use_rs2_d = 1'b1;
        rd_d      = '0;
      end
      OPCODE_JAL: begin
        imm_d = imm_jtype;
      end
      OPCODE_JALR, OPCODE_MISCMEM, OPCODE_SYSTEM: begin
        // Legal, nothing to execute here
      end
      default: begin
        illegal_d = 1'b1;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Decode stage registers

  // Control flags, qualified by the strobe
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      valid_o   <= 1'b0;
      illegal_o <= 1'b0;
      wb_o      <= 1'b0;
      lsu_req_o <= 1'b0;
    end else begin
      valid_o   <= instr_valid_i;
      illegal_o <= instr_valid_i & illegal_d;
      wb_o      <= instr_valid_i & wb_d;
      lsu_req_o <= instr_valid_i & lsu_req_d;
    end
  end

  // Payload, loaded only with a new instruction
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      alu_op_o   <= alu_op_d;
      use_rs2_o  <= use_rs2_d;
      use_pc_o   <= use_pc_d;
      zero_a_o   <= zero_a_d;
      rs1_o      <= rs1_field;
      rs2_o      <= rs2_field;
      rd_o       <= rd_d;
      imm_o      <= imm_d;
      pc_o       <= pc_i;
      lsu_ctrl_o <= {opcode[5], funct3};  // Store flag above size/sign
    end
  end

endmodule

// File: rtl/rv_exec_top.sv
//////////////////////////////////////////////////
// RV32I decode / execute top
// Decoder, register file and ALU, 2-cycle latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_exec_top import rv_core_pkg::*; #(
  parameter int unsigned REG_COUNT = 32
) (
  input  logic      clk_i,
  input  logic      rstn_i,

  input  logic      instr_valid_i,
  input  word_t     instr_i,
  input  word_t     pc_i,

  // Writeback
  output logic      wb_valid_o,
  output reg_addr_t wb_rd_o,
  output word_t     wb_data_o,

  // Memory request
  output logic      lsu_req_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output word_t     lsu_addr_o,
  output word_t     lsu_wdata_o,
  output reg_addr_t lsu_rd_o,

  output logic      illegal_o
);

  // Decoder to execute
  logic      dec_valid;
  logic      dec_illegal;
  alu_op_t   dec_alu_op;
  logic      dec_use_rs2;
  logic      dec_use_pc;
  logic      dec_zero_a;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  word_t     dec_imm;
  word_t     dec_pc;
  logic      dec_wb;
  logic      dec_lsu_req;
  lsu_ctrl_t dec_lsu_ctrl;

  // Register file reads
  word_t     rs_a_data;
  word_t     rs_b_data;

  // Execute outputs, also the write port
  word_t     alu_result;
  reg_addr_t alu_rd;
  logic      alu_wb_valid;

  //////////////////////////////////////////////////
  // Decode stage
  rv_decoder u_decoder (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .valid_o       (dec_valid),
    .illegal_o     (dec_illegal),
    .alu_op_o      (dec_alu_op),
    .use_rs2_o     (dec_use_rs2),
    .use_pc_o      (dec_use_pc),
    .zero_a_o      (dec_zero_a),
    .rs1_o         (dec_rs1),
    .rs2_o         (dec_rs2),
    .rd_o          (dec_rd),
    .imm_o         (dec_imm),
    .pc_o          (dec_pc),
    .wb_o          (dec_wb),
    .lsu_req_o     (dec_lsu_req),
    .lsu_ctrl_o    (dec_lsu_ctrl)
  );

  // Write at N+2 is visible to the next read, no forwarding
  rv_regfile #(
    .REG_COUNT (REG_COUNT)
  ) u_regfile (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .raddr_a_i (dec_rs1),
    .raddr_b_i (dec_rs2),
    .rdata_a_o (rs_a_data),
    .rdata_b_o (rs_b_data),
    .we_i      (alu_wb_valid),
    .waddr_i   (alu_rd),
    .wdata_i   (alu_result)
  );

  //////////////////////////////////////////////////
  // Execute stage
  rv_alu u_alu (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .valid_i     (dec_valid),
    .illegal_i   (dec_illegal),
    .alu_op_i    (dec_alu_op),
    .use_rs2_i   (dec_use_rs2),
    .use_pc_i    (dec_use_pc),
    .zero_a_i    (dec_zero_a),
    .rs_a_i      (rs_a_data),
    .rs_b_i      (rs_b_data),
    .imm_i       (dec_imm),
    .pc_i        (dec_pc),
    .rd_i        (dec_rd),
    .wb_i        (dec_wb),
    .lsu_req_i   (dec_lsu_req),
    .lsu_ctrl_i  (dec_lsu_ctrl),
    .result_o    (alu_result),
    .rd_o        (alu_rd),
    .wb_valid_o  (alu_wb_valid),
    .lsu_req_o   (lsu_req_o),
    .lsu_ctrl_o  (lsu_ctrl_o),
    .lsu_wdata_o (lsu_wdata_o),
    .illegal_o   (illegal_o)
  );

  assign wb_valid_o = alu_wb_valid;
  assign wb_rd_o    = alu_rd;
  assign wb_data_o  = alu_result;
  assign lsu_addr_o = alu_result;  // Effective address
  assign lsu_rd_o   = alu_rd;

endmodule

// File: rtl/rv_regfile.sv
//////////////////////////////////////////////////
// Integer register file
// Two async read ports, one sync write, x0 = 0
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; #(
  parameter int unsigned REG_COUNT = 32
) (
  input  logic      clk_i,
  input  logic      rstn_i,

  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o,

  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  word_t     wdata_i
);

  word_t regs_q [REG_COUNT];

  // Entry 0 is never written, so it stays zero after reset
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && waddr_i < REG_COUNT) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Indices outside the file read as zero
  // Data being written this cycle passes straight to a read of the same entry
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0 && raddr_a_i < REG_COUNT) begin
      rdata_a_o = (we_i && waddr_i == raddr_a_i) ? wdata_i : regs_q[raddr_a_i];
    end
    if (raddr_b_i != '0 && raddr_b_i < REG_COUNT) begin
      rdata_b_o = (we_i && waddr_i == raddr_b_i) ? wdata_i : regs_q[raddr_b_i];
    end
  end

endmodule

// File: tests/rv_ref_model.svh
//////////////////////////////////////////////////
// RV32I reference model for the execute testbench
// Shadow registers, expected results, encoders
//////////////////////////////////////////////////

`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

typedef struct packed {
  logic      wb;
  logic      lsu;
  logic      illegal;
  reg_addr_t rd;
  word_t     data;     // Writeback data or memory address
  lsu_ctrl_t ctrl;
  word_t     wdata;
} expect_t;

word_t shadow_regs [32];  // Architectural view in program order

function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_SLL:  return a << b[4:0];
    ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
    ALU_XOR:  return a ^ b;
    ALU_SRL:  return a >> b[4:0];
    ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
    ALU_OR:   return a | b;
    ALU_AND:  return a & b;
    default:  return 32'h0;
  endcase
endfunction

// Expected outputs of one instruction, updates the shadow file
function automatic expect_t ref_execute(word_t instr, word_t pc);
  expect_t    e;
  logic [2:0] f3;
  word_t      a;
  word_t      b;
  word_t      imm_i;
  e     = '0;
  f3    = instr[14:12];
  a     = shadow_regs[instr[19:15]];
  b     = shadow_regs[instr[24:20]];
  imm_i = {{20{instr[31]}}, instr[31:20]};
  e.rd  = instr[11:7];
  case (opcode_t'(instr[6:0]))
    OPCODE_OPIMM: begin
      e.wb   = 1'b1;
      e.data = ref_alu({(f3 == 3'b101) & instr[30], f3}, a, imm_i);  // Bit 30 is SRAI only
    end
    OPCODE_OP:    {e.wb, e.data} = {1'b1, ref_alu({instr[30], f3}, a, b)};
    OPCODE_LUI:   {e.wb, e.data} = {1'b1, instr[31:12], 12'h000};
    OPCODE_AUIPC: {e.wb, e.data} = {1'b1, pc + {instr[31:12], 12'h000}};
    OPCODE_LOAD:  {e.lsu, e.data, e.ctrl} = {1'b1, a + imm_i, 1'b0, f3};
    OPCODE_STORE: begin
      {e.lsu, e.ctrl, e.wdata} = {1'b1, 1'b1, f3, b};
      e.data = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
    end
    OPCODE_BRANCH, OPCODE_JAL, OPCODE_JALR, OPCODE_MISCMEM, OPCODE_SYSTEM: ;
    default:      e.illegal = 1'b1;
  endcase
  if (e.wb && e.rd != 5'd0) shadow_regs[e.rd] = e.data;
  return e;
endfunction

function automatic word_t enc_r(alu_op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
  return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rd, OPCODE_OP};
endfunction

function automatic word_t enc_i(opcode_t opc, logic [2:0] f3, reg_addr_t rd,
                                reg_addr_t rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
endfunction

`endif

// File: tests/tb_rv_exec_top.sv
//////////////////////////////////////////////////
// Testbench for the RV32I decode / execute top
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_rv_exec_top import rv_core_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int DRAIN       = 3;   // Idle slots that flush the 2-cycle pipe
  localparam int N_OPIMM     = 200;
  localparam int N_OP        = 200;
  localparam int N_UPPER     = 60;
  localparam int N_MEM       = 100;
  localparam int N_OTHER     = 60;
  localparam int TOTAL_INSTR = 32 + N_OPIMM + N_OP + N_UPPER + N_MEM + N_OTHER;

  logic      clk = 1'b0;
  logic      rstn = 1'b0;
  logic      instr_valid = 1'b0;
  word_t     instr = '0;
  word_t     pc = '0;
  logic      wb_valid, lsu_req, illegal;
  reg_addr_t wb_rd, lsu_rd;
  word_t     wb_data, lsu_addr, lsu_wdata;
  lsu_ctrl_t lsu_ctrl;

  integer seed = 32'h0fd2_d7e7;
  int     errors = 0;
  int     checks = 0;

  `include "rv_ref_model.svh"

  expect_t exp_q [$];  // One slot per cycle, idle slots included

  rv_exec_top dut (
    .clk_i (clk), .rstn_i (rstn),
    .instr_valid_i (instr_valid), .instr_i (instr), .pc_i (pc),
    .wb_valid_o (wb_valid), .wb_rd_o (wb_rd), .wb_data_o (wb_data),
    .lsu_req_o (lsu_req), .lsu_ctrl_o (lsu_ctrl), .lsu_addr_o (lsu_addr),
    .lsu_wdata_o (lsu_wdata), .lsu_rd_o (lsu_rd), .illegal_o (illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(string name, word_t got, word_t want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
    end
  endtask

  task automatic issue(word_t new_instr, word_t new_pc);
    @(negedge clk);
    {instr_valid, instr, pc} = {1'b1, new_instr, new_pc};
    exp_q.push_back(ref_execute(new_instr, new_pc));
  endtask

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      instr_valid = 1'b0;
      exp_q.push_back('0);
    end
  endtask

  task automatic end_test(string name, int start_errors);
    idle(DRAIN);
    if (errors == start_errors) $display("%-12s ok", name);
    else $display("%-12s %0d errors", name, errors - start_errors);
  endtask

  function automatic opcode_t nonexec_opcode(int k);
    case (k)
      0:       return OPCODE_BRANCH;
      1:       return OPCODE_JAL;
      2:       return OPCODE_JALR;
      3:       return OPCODE_MISCMEM;
      default: return OPCODE_SYSTEM;
    endcase
  endfunction

  function automatic logic known_opcode(opcode_t opc);
    return opc inside {OPCODE_LOAD, OPCODE_MISCMEM, OPCODE_OPIMM, OPCODE_AUIPC,
                       OPCODE_STORE, OPCODE_OP, OPCODE_LUI, OPCODE_BRANCH,
                       OPCODE_JALR, OPCODE_JAL, OPCODE_SYSTEM};
  endfunction

  //////////////////////////////////////////////////
  // Comparison, slot pushed 2 edges before
  initial begin : compare_outputs
    expect_t e;
    forever begin
      @(posedge clk);
      #1;
      if (exp_q.size() >= 2) begin
        e = exp_q.pop_front();
        checks += 3;
        if (wb_valid !== e.wb) begin
          errors++;
          $display("%s writeback pulse", e.wb ? "Missing" : "Unexpected");
        end
        if (lsu_req !== e.lsu) begin
          errors++;
          $display("%s memory request pulse", e.lsu ? "Missing" : "Unexpected");
        end
        if (illegal !== e.illegal) begin
          errors++;
          $display("%s illegal instruction pulse", e.illegal ? "Missing" : "Unexpected");
        end
        if (e.wb && wb_valid) begin
          check_value("wb_rd_o", wb_rd, e.rd);
          check_value("wb_data_o", wb_data, e.data);
        end
        if (e.lsu && lsu_req) begin
          check_value("lsu_ctrl_o", lsu_ctrl, e.ctrl);
          check_value("lsu_addr_o", lsu_addr, e.data);
          if (e.ctrl[3]) check_value("lsu_wdata_o", lsu_wdata, e.wdata);
          else check_value("lsu_rd_o", lsu_rd, e.rd);
        end
      end
    end
  end

  initial begin : watchdog
    #((TOTAL_INSTR + 7 * DRAIN + 20) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus
  initial begin : stimulus
    word_t      r;
    int         k;
    int         start;
    logic [2:0] f3;
    opcode_t    opc;
    for (int i = 0; i < 32; i++) shadow_regs[i] = '0;
    repeat (2) @(negedge clk);
    rstn = 1'b1;

    start = errors;
    idle(DRAIN);  // No pulse without an instruction
    // Every register reads zero
    for (int i = 0; i < 32; i++) issue(enc_i(OPCODE_OPIMM, 3'b000, i, i, 12'h000), '0);
    end_test("reset_state", start);

    start = errors;
    for (int i = 0; i < N_OPIMM; i++) begin
      r  = $random(seed);
      f3 = r[14:12];
      if (f3 == 3'b001) issue(enc_i(OPCODE_OPIMM, f3, r[9:7], r[17:15], {7'b0, r[24:20]}), '0);
      else if (f3 == 3'b101)
        issue(enc_i(OPCODE_OPIMM, f3, r[9:7], r[17:15], {1'b0, r[30], 5'b0, r[24:20]}), '0);
      else issue(enc_i(OPCODE_OPIMM, f3, r[9:7], r[17:15], r[31:20]), '0);
    end
    end_test("op_imm", start);

    start = errors;  // rd of x0 one time in eight
    for (int i = 0; i < N_OP; i++) begin
      r = $random(seed);
      k = r % 10;
      issue(enc_r((k < 8) ? alu_op_t'(k) : ((k == 8) ? ALU_SUB : ALU_SRA),
                  r[9:7], r[17:15], r[22:20]), '0);
    end
    end_test("op_reg", start);

    start = errors;
    for (int i = 0; i < N_UPPER; i++) begin
      r   = $random(seed);
      opc = r[0] ? OPCODE_LUI : OPCODE_AUIPC;
      issue({r[31:12], 2'b00, r[9:7], opc}, $random(seed) & ~32'h3);
    end
    end_test("lui_auipc", start);

    start = errors;
    for (int i = 0; i < N_MEM; i++) begin
      r = $random(seed);
      k = r % 5;
      if (r[31]) begin
        issue(enc_s(3'(k % 3), r[17:15], r[22:20], r[30:19]), '0);
      end else begin
        f3 = (k < 3) ? 3'(k) : 3'(k + 1);  // LB LH LW LBU LHU
        issue(enc_i(OPCODE_LOAD, f3, r[9:7], r[17:15], r[30:19]), '0);
      end
    end
    end_test("load_store", start);

    start = errors;
    for (int i = 0; i < N_OTHER; i++) begin
      r = $random(seed);
      if (i % 2 == 0) begin
        opc = nonexec_opcode(r % 5);
      end else begin
        opc = r[6:0];
        while (known_opcode(opc)) opc = opc + 7'd1;
      end
      issue({r[31:7], opc}, r & ~32'h3);
    end
    end_test("other_ops", start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) $display("TEST PASS");
    else $display("TEST FAIL");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tests
rtl/rv_core_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_exec_top.sv
tests/tb_rv_exec_top.sv
